// ==== filelist.f ====
verilog/roundPkg.sv
verilog/multPkg.sv
verilog/subKaratsuba.sv
verilog/karatsubaMult.sv
verilog/multPipeCtrl.sv
verilog/significandNormalizer.sv
verilog/significandMultUnit.sv
verification/significandMultUnit_props.sv
verification/significandMultUnit_tb.sv

// ==== verification/significandMultUnit_tb.sv ====
`timescale 1ns/1ps

module significandMultUnit_tb;

    import multPkg::*;
    import roundPkg::*;

    // ==============================
    // Run constants and types
    // ==============================

    localparam int TABLE_LEN = 20;
    localparam int RAND_COUNT = 200;
    // Start sample to valid_o high
    localparam int LATENCY = 3;
    localparam int TIMEOUT_CYCLES = (TABLE_LEN + RAND_COUNT + 3) * 4;

    // Directed entry
    typedef struct packed {
        sigOperands_t ops;
        normResult_t  expected;
    } vector_t;

    // Issued item waiting for its valid_o
    typedef struct packed {
        normResult_t expected;
        logic [31:0] issueCycle;
    } pending_t;

    // Low from the start so no edge occurs at time zero
    logic         clk = 1'b0;
    logic         arstN;
    logic         start;
    sigOperands_t operands;
    logic         valid;
    normResult_t  result;

    vector_t     vectors [TABLE_LEN];
    pending_t    pending [$];
    logic [31:0] seed;
    int          cycleCount = 0;
    int          errors = 0;
    int          checks = 0;

    significandMultUnit significandMultUnit_inst (
        .clk        (clk),
        .arstN_i    (arstN),
        .start_i    (start),
        .operands_i (operands),
        .valid_o    (valid),
        .result_o   (result)
    );

    bind significandMultUnit significandMultUnit_props propsInst (
        .clk      (clk),
        .arstN_i  (arstN_i),
        .start_i  (start_i),
        .valid_i  (valid_o),
        .result_i (result_o)
    );

    // 100 ns period
    initial begin
        forever begin
            #50 clk = ~clk;
        end
    end

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic vector_t makeVector(input logic [SIG_W-1:0] a, input logic [SIG_W-1:0] b,
                                           input roundMode_e mode, input logic [SIG_W-1:0] mant,
                                           input logic [1:0] inc, input logic inexact);
        vector_t v;
        v.ops.sigA = a;
        v.ops.sigB = b;
        v.ops.roundMode = mode;
        v.expected.mantissa = mant;
        v.expected.expInc = inc;
        v.expected.inexact = inexact;
        return v;
    endfunction

    // Reference model multiplies directly, moves the leading one to bit 47 and rounds
    function automatic normResult_t modelResult(input logic [SIG_W-1:0] a,
                                                input logic [SIG_W-1:0] b, input roundMode_e mode);
        logic [PROD_W-1:0] prod;
        logic [PROD_W-1:0] aligned;
        logic [1:0]        inc;
        logic              g;
        logic              s;
        logic              up;
        logic [SIG_W:0]    sum;
        normResult_t       r;
        prod = PROD_W'(a) * PROD_W'(b);
        if (prod[PROD_W-1]) begin
            aligned = prod;
            inc = 2'd1;
        end else begin
            aligned = prod << 1;
            inc = 2'd0;
        end
        g = aligned[SIG_W-1];
        s = |aligned[SIG_W-2:0];
        case (mode)
            RND_NEAREST_EVEN: up = g && (s || aligned[SIG_W]);
            RND_AWAY:         up = g || s;
            default:          up = 1'b0;
        endcase
        sum = aligned[PROD_W-1:SIG_W] + up;
        if (sum[SIG_W]) begin
            // Carry out renormalizes
            r.mantissa = {1'b1, {(SIG_W-1){1'b0}}};
            inc = inc + 2'd1;
        end else begin
            r.mantissa = sum[SIG_W-1:0];
        end
        r.expInc = inc;
        r.inexact = g || s;
        return r;
    endfunction

    // Expected values from the alignment and rounding rules
    task automatic loadVectors;
        // 1.0 x 1.0 and 1.5 x 1.5
        vectors[0]  = makeVector(24'h800000, 24'h800000, RND_TRUNC, 24'h800000, 2'd0, 1'b0);
        vectors[1]  = makeVector(24'hC00000, 24'hC00000, RND_TRUNC, 24'h900000, 2'd1, 1'b0);
        vectors[2]  = makeVector(24'hC00000, 24'hC00000, RND_AWAY, 24'h900000, 2'd1, 1'b0);
        // Exact tie with an odd lsb
        vectors[3]  = makeVector(24'h800001, 24'hC00000, RND_NEAREST_EVEN, 24'hC00002, 2'd0, 1'b1);
        vectors[4]  = makeVector(24'h800001, 24'hC00000, RND_TRUNC, 24'hC00001, 2'd0, 1'b1);
        vectors[5]  = makeVector(24'h800001, 24'hC00000, RND_AWAY, 24'hC00002, 2'd0, 1'b1);
        // Exact tie with an even lsb
        vectors[6]  = makeVector(24'h800002, 24'hA00000, RND_NEAREST_EVEN, 24'hA00002, 2'd0, 1'b1);
        vectors[7]  = makeVector(24'h800002, 24'hA00000, RND_AWAY, 24'hA00003, 2'd0, 1'b1);
        // Guard and sticky both set
        vectors[8]  = makeVector(24'h800001, 24'hC00001, RND_TRUNC, 24'hC00002, 2'd0, 1'b1);
        vectors[9]  = makeVector(24'h800001, 24'hC00001, RND_NEAREST_EVEN, 24'hC00003, 2'd0, 1'b1);
        vectors[10] = makeVector(24'h800001, 24'hC00001, RND_AWAY, 24'hC00003, 2'd0, 1'b1);
        // Sticky only
        vectors[11] = makeVector(24'h800001, 24'h800001, RND_NEAREST_EVEN, 24'h800002, 2'd0, 1'b1);
        vectors[12] = makeVector(24'h800001, 24'h800001, RND_AWAY, 24'h800003, 2'd0, 1'b1);
        // All ones with the top bit set cannot carry out
        vectors[13] = makeVector(24'hFFFFFF, 24'hFFFFFF, RND_TRUNC, 24'hFFFFFE, 2'd1, 1'b1);
        vectors[14] = makeVector(24'hFFFFFF, 24'hFFFFFF, RND_AWAY, 24'hFFFFFF, 2'd1, 1'b1);
        // Product just below 2^47 carries out when rounded up
        vectors[15] = makeVector(24'hFFFFFE, 24'h800001, RND_AWAY, 24'h800000, 2'd1, 1'b1);
        vectors[16] = makeVector(24'hFFFFFE, 24'h800001, RND_NEAREST_EVEN, 24'h800000, 2'd1, 1'b1);
        vectors[17] = makeVector(24'hFFFFFE, 24'h800001, RND_TRUNC, 24'hFFFFFF, 2'd0, 1'b1);
        // Zero operands
        vectors[18] = makeVector(24'h000000, 24'h800000, RND_AWAY, 24'h000000, 2'd0, 1'b0);
        vectors[19] = makeVector(24'h000000, 24'h000000, RND_NEAREST_EVEN, 24'h000000, 2'd0, 1'b0);
    endtask

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s is 0x%0h, expected 0x%0h at cycle %0d",
                     name, actual, expected, cycleCount);
        end
    endtask

    // Drives one start strobe on the falling edge
    task automatic issueOp(input sigOperands_t ops, input normResult_t expected);
        pending_t entry;
        @(negedge clk);
        start = 1'b1;
        operands = ops;
        entry.expected = expected;
        entry.issueCycle = cycleCount;
        pending.push_back(entry);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            start = 1'b0;
        end
    endtask

    task automatic reportAndFinish(input bit timedOut);
        int propFails;
        propFails = significandMultUnit_inst.propsInst.failCount;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, propFails);
        if (errors == 0 && propFails == 0 && !timedOut) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // ==============================
    // Watchdog and monitor
    // ==============================

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: pipeline still busy after %0d cycles", cycleCount);
            reportAndFinish(1'b1);
        end
    end

    // Outputs settled half a cycle after the edge
    always @(negedge clk) begin : monitor
        pending_t head;
        logic     dueNow;
        dueNow = 1'b0;
        if (pending.size() > 0) begin
            dueNow = (pending[0].issueCycle + LATENCY == cycleCount);
        end
        checkValue("valid_o", valid, dueNow);
        if (dueNow) begin
            head = pending.pop_front();
            checkValue("result_o.mantissa", result.mantissa, head.expected.mantissa);
            checkValue("result_o.expInc", result.expInc, head.expected.expInc);
            checkValue("result_o.inexact", result.inexact, head.expected.inexact);
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    initial begin : mainFlow
        sigOperands_t randOps;
        arstN = 1'b0;
        start = 1'b0;
        operands = '0;
        seed = 32'hbf99_9fd6;
        loadVectors();
        repeat (16) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        // valid_o stays low before the first start
        idleCycles(4);
        // Directed table issued back to back
        for (int i = 0; i < TABLE_LEN; i++) begin
            issueOp(vectors[i].ops, vectors[i].expected);
        end
        idleCycles(5);
        // Random pairs with the msb forced
        for (int i = 0; i < RAND_COUNT; i++) begin
            seed = lcgNext(seed);
            randOps.sigA = {1'b1, seed[31:9]};
            seed = lcgNext(seed);
            randOps.sigB = {1'b1, seed[31:9]};
            seed = lcgNext(seed);
            randOps.roundMode = roundMode_e'(2'(seed[31:16] % 3));
            issueOp(randOps, modelResult(randOps.sigA, randOps.sigB, randOps.roundMode));
        end
        idleCycles(1);
        while (pending.size() != 0) begin
            @(negedge clk);
        end
        // No stray valid_o once drained
        idleCycles(4);
        reportAndFinish(1'b0);
    end

endmodule

// ==== verification/significandMultUnit_props.sv ====
`timescale 1ns/1ps

module significandMultUnit_props (
    input logic                  clk,
    input logic                  arstN_i,
    input logic                  start_i,
    input logic                  valid_i,
    input roundPkg::normResult_t result_i
);

    import roundPkg::*;

    // Read by the testbench summary
    int failCount = 0;

    // ==============================
    // Pipeline strobes
    // ==============================

    // Fixed three edge latency
    assert property (@(posedge clk) disable iff (!arstN_i)
        valid_i == $past(start_i, 3))
        else begin
            failCount++;
            $error("valid_o does not follow start_i by three edges");
        end

    // Quiet while in reset
    assert property (@(posedge clk) !arstN_i |-> !valid_i)
        else begin
            failCount++;
            $error("valid_o high during reset");
        end

    // Normalized or all zero
    assert property (@(posedge clk) disable iff (!arstN_i)
        valid_i |-> (result_i.mantissa[MANT_W-1] || result_i == '0))
        else begin
            failCount++;
            $error("result_o mantissa msb clear on a nonzero result");
        end

endmodule

// ==== verilog/significandMultUnit.sv ====
`timescale 1ns/1ps

module significandMultUnit (
    input  logic                  clk,
    input  logic                  arstN_i,
    input  logic                  start_i,
    input  multPkg::sigOperands_t operands_i,
    output logic                  valid_o,
    output roundPkg::normResult_t result_o
);

    import multPkg::*;
    import roundPkg::*;

    // Staged significands
    logic [SIG_W-1:0]  sigA;
    logic [SIG_W-1:0]  sigB;
    // Stage strobes
    logic              loadResult;
    logic              loadNorm;
    // Mode aligned to the product
    roundMode_e        roundMode;
    logic [PROD_W-1:0] product;

    // ==============================
    // Pipeline stages
    // ==============================

    // Edge E0, operands in
    multPipeCtrl multPipeCtrl_inst (
        .clk          (clk),
        .arstN_i      (arstN_i),
        .start_i      (start_i),
        .operands_i   (operands_i),
        .sigA_o       (sigA),
        .sigB_o       (sigB),
        .loadResult_o (loadResult),
        .loadNorm_o   (loadNorm),
        .roundMode_o  (roundMode),
        .valid_o      (valid_o)
    );

    // Edge E1, product registered
    karatsubaMult karatsubaMult_inst (
        .clk          (clk),
        .arstN_i      (arstN_i),
        .loadResult_i (loadResult),
        .dataA_i      (sigA),
        .dataB_i      (sigB),
        .sgfResult_o  (product)
    );

    // Edge E2, rounded result registered
    significandNormalizer significandNormalizer_inst (
        .clk         (clk),
        .arstN_i     (arstN_i),
        .load_i      (loadNorm),
        .product_i   (product),
        .roundMode_i (roundMode),
        .result_o    (result_o)
    );

endmodule

// ==== verilog/significandNormalizer.sv ====
`timescale 1ns/1ps

module significandNormalizer (
    input  logic                       clk,
    input  logic                       arstN_i,
    input  logic                       load_i,
    input  logic [multPkg::PROD_W-1:0] product_i,
    input  roundPkg::roundMode_e       roundMode_i,
    output roundPkg::normResult_t      result_o
);

    import multPkg::*;
    import roundPkg::*;

    // Product msb set, one bit shift needed
    logic             topSet;
    logic [SIG_W-1:0] keptMant;
    logic             guard;
    logic             sticky;
    logic             roundUp;
    // Extra bit catches the rounding carry
    logic [SIG_W:0]   roundedMant;
    normResult_t      nextResult;

    // ==============================
    // Alignment
    // ==============================

    assign topSet = product_i[PROD_W-1];

    always_comb begin
        if (topSet) begin
            keptMant = product_i[PROD_W-1 -: SIG_W];
            guard    = product_i[PROD_W-SIG_W-1];
            sticky   = |product_i[PROD_W-SIG_W-2:0];
        end else begin
            // Leading one in bit 46, or a zero product
            keptMant = product_i[PROD_W-2 -: SIG_W];
            guard    = product_i[PROD_W-SIG_W-2];
            sticky   = |product_i[PROD_W-SIG_W-3:0];
        end
    end

    // ==============================
    // Rounding
    // ==============================

    always_comb begin
        case (roundMode_i)
            // Ties go to the even mantissa
            RND_NEAREST_EVEN: roundUp = guard & (sticky | keptMant[0]);
            RND_AWAY:         roundUp = guard | sticky;
            // Truncate, also for the unused code
            default:          roundUp = 1'b0;
        endcase
    end

    assign roundedMant = {1'b0, keptMant} + (SIG_W+1)'(roundUp);

    always_comb begin
        nextResult.inexact = guard | sticky;
        if (roundedMant[SIG_W]) begin
            // All ones rounded over, renormalize
            nextResult.mantissa = {1'b1, {(SIG_W-1){1'b0}}};
            nextResult.expInc   = {1'b0, topSet} + 2'd1;
        end else begin
            nextResult.mantissa = roundedMant[SIG_W-1:0];
            nextResult.expInc   = {1'b0, topSet};
        end
    end

    // Output register
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            result_o <= '0;
        end else if (load_i) begin
            result_o <= nextResult;
        end
    end

endmodule

// ==== verilog/multPipeCtrl.sv ====
`timescale 1ns/1ps

module multPipeCtrl (
    input  logic                      clk,
    input  logic                      arstN_i,
    input  logic                      start_i,
    input  multPkg::sigOperands_t     operands_i,
    output logic [multPkg::SIG_W-1:0] sigA_o,
    output logic [multPkg::SIG_W-1:0] sigB_o,
    output logic                      loadResult_o,
    output logic                      loadNorm_o,
    output roundPkg::roundMode_e      roundMode_o,
    output logic                      valid_o
);

    import multPkg::*;
    import roundPkg::*;

    // Operand staging
    sigOperands_t opsQ;
    // Mode for the item now in the multiplier result register
    roundMode_e   roundModeQ;
    // Strobe chain
    logic         loadResultQ;
    logic         loadNormQ;
    logic         validQ;

    // ==============================
    // Operand staging
    // ==============================

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            opsQ <= '0;
        end else if (start_i) begin
            opsQ <= operands_i;
        end
    end

    // Follows the product into the multiplier result register
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            roundModeQ <= RND_TRUNC;
        end else if (loadResultQ) begin
            roundModeQ <= opsQ.roundMode;
        end
    end

    // ==============================
    // Strobe pipeline
    // ==============================

    // One stage per edge, back-to-back starts allowed
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            loadResultQ <= 1'b0;
            loadNormQ   <= 1'b0;
            validQ      <= 1'b0;
        end else begin
            loadResultQ <= start_i;
            loadNormQ   <= loadResultQ;
            validQ      <= loadNormQ;
        end
    end

    assign sigA_o       = opsQ.sigA;
    assign sigB_o       = opsQ.sigB;
    assign loadResult_o = loadResultQ;
    assign loadNorm_o   = loadNormQ;
    assign roundMode_o  = roundModeQ;
    assign valid_o      = validQ;

endmodule

// ==== verilog/karatsubaMult.sv ====
`timescale 1ns/1ps

module karatsubaMult (
    input  logic                      clk,
    input  logic                      arstN_i,
    input  logic                      loadResult_i,
    input  logic [multPkg::SIG_W-1:0] dataA_i,
    input  logic [multPkg::SIG_W-1:0] dataB_i,
    output logic [multPkg::PROD_W-1:0] sgfResult_o
);

    import multPkg::*;

    // Split of the 24 bit significands
    localparam int HW = SIG_W / 2;
    localparam int LW = SIG_W - HW;
    // Carry bit on the half sums
    localparam int MW = LW + 1;

    // Half sums
    logic [MW-1:0]     sumA;
    logic [MW-1:0]     sumB;
    // Sub-products
    logic [2*HW-1:0]   qLeft;
    logic [2*LW-1:0]   qRight;
    logic [2*MW-1:0]   qMiddle;
    logic [2*MW-1:0]   qCross;
    // Combined product ahead of the register
    logic [PROD_W-1:0] product;

    // ==============================
    // Operand split
    // ==============================

    assign sumA = MW'(dataA_i[SIG_W-1 -: HW]) + MW'(dataA_i[LW-1:0]);
    assign sumB = MW'(dataB_i[SIG_W-1 -: HW]) + MW'(dataB_i[LW-1:0]);

    // Upper halves
    subKaratsuba #(.SW(HW)) left (
        .dataA_i (dataA_i[SIG_W-1 -: HW]),
        .dataB_i (dataB_i[SIG_W-1 -: HW]),
        .dataS_o (qLeft)
    );

    // Lower halves
    subKaratsuba #(.SW(LW)) right (
        .dataA_i (dataA_i[LW-1:0]),
        .dataB_i (dataB_i[LW-1:0]),
        .dataS_o (qRight)
    );

    // Sum of halves
    subKaratsuba #(.SW(MW)) middle (
        .dataA_i (sumA),
        .dataB_i (sumB),
        .dataS_o (qMiddle)
    );

    // ==============================
    // Combine and register
    // ==============================

    assign qCross = qMiddle - (2*MW)'(qLeft) - (2*MW)'(qRight);

    assign product = (PROD_W'(qLeft) << (2 * LW))
                   + (PROD_W'(qCross) << LW)
                   + PROD_W'(qRight);

    // Result register, held between strobes
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            sgfResult_o <= '0;
        end else if (loadResult_i) begin
            sgfResult_o <= product;
        end
    end

endmodule

// ==== verilog/subKaratsuba.sv ====
`timescale 1ns/1ps

module subKaratsuba #(
    parameter int SW = 12
) (
    input  logic [SW-1:0]   dataA_i,
    input  logic [SW-1:0]   dataB_i,
    output logic [2*SW-1:0] dataS_o
);

    import multPkg::*;

    // Product width at this level
    localparam int PW = 2 * SW;
    // Upper half, one bit short on odd widths
    localparam int HW = SW / 2;
    // Lower half
    localparam int LW = SW - HW;
    // Half sums need a carry bit
    localparam int MW = LW + 1;

    generate
        if (SW <= KOA_STOP_W) begin : gDirect

            // Small enough for a plain multiplier
            assign dataS_o = PW'(dataA_i) * PW'(dataB_i);

        end else begin : gSplit

            // Half sums feeding the middle product
            logic [MW-1:0]   sumA;
            logic [MW-1:0]   sumB;
            // Sub-products
            logic [2*HW-1:0] qLeft;
            logic [2*LW-1:0] qRight;
            logic [2*MW-1:0] qMiddle;
            // Cross terms, middle minus left minus right
            logic [2*MW-1:0] qCross;

            assign sumA = MW'(dataA_i[SW-1 -: HW]) + MW'(dataA_i[LW-1:0]);
            assign sumB = MW'(dataB_i[SW-1 -: HW]) + MW'(dataB_i[LW-1:0]);

            // ==============================
            // Recursive sub-products
            // ==============================

            // Upper halves
            subKaratsuba #(.SW(HW)) left (
                .dataA_i (dataA_i[SW-1 -: HW]),
                .dataB_i (dataB_i[SW-1 -: HW]),
                .dataS_o (qLeft)
            );

            // Lower halves
            subKaratsuba #(.SW(LW)) right (
                .dataA_i (dataA_i[LW-1:0]),
                .dataB_i (dataB_i[LW-1:0]),
                .dataS_o (qRight)
            );

            // Half sums
            subKaratsuba #(.SW(MW)) middle (
                .dataA_i (sumA),
                .dataB_i (sumB),
                .dataS_o (qMiddle)
            );

            // Never negative, equals aHi*bLo + aLo*bHi
            assign qCross = qMiddle - (2*MW)'(qLeft) - (2*MW)'(qRight);

            // Left at the full low width, cross terms at the half width
            assign dataS_o = (PW'(qLeft) << (2 * LW))
                           + (PW'(qCross) << LW)
                           + PW'(qRight);

        end
    endgenerate

endmodule

// ==== verilog/multPkg.sv ====
package multPkg;

    // ==============================
    // Multiplier datapath widths
    // ==============================

    // Significand width tracks the rounded mantissa width
    localparam int SIG_W = roundPkg::MANT_W;
    // Full product
    localparam int PROD_W = 2 * SIG_W;
    // Recursion ends here, plain multiply below
    localparam int KOA_STOP_W = 7;

    // Operands as issued by the FPU front end, 50 bits
    typedef struct packed {
        logic [SIG_W-1:0]     sigA;
        logic [SIG_W-1:0]     sigB;
        // Travels with the operands
        roundPkg::roundMode_e roundMode;
    } sigOperands_t;

endpackage

// ==== verilog/roundPkg.sv ====
package roundPkg;

    // ==============================
    // Rounded significand
    // ==============================

    // Kept mantissa width, hidden bit included
    localparam int MANT_W = 24;

    // Rounding mode opcode
    typedef enum logic [1:0] {
        // Discarded bits dropped
        RND_TRUNC        = 2'd0,
        // Nearest, ties to even
        RND_NEAREST_EVEN = 2'd1,
        // Up on any discarded bit
        RND_AWAY         = 2'd2
    } roundMode_e;

    // Normalizer output word, 27 bits
    typedef struct packed {
        logic [MANT_W-1:0] mantissa;
        // Exponent increment, 0 to 2
        logic [1:0]        expInc;
        logic              inexact;
    } normResult_t;

endpackage
